// ==== logic/isa_pkg.sv ====
/* Machine word and address types, opcode enum, decoded instruction,
   architectural register view and memory request structs */
package isa_pkg;

  typedef logic [11:0] word_t;
  typedef logic [11:0] addr_t;

  localparam word_t HALT_WORD = 12'o7402;  // HLT microinstruction

  typedef enum logic [2:0] {
    OP_AND = 3'o0,
    OP_TAD = 3'o1,
    OP_ISZ = 3'o2,
    OP_DCA = 3'o3,
    OP_JMS = 3'o4,
    OP_JMP = 3'o5,
    OP_IOT = 3'o6,
    OP_OPR = 3'o7
  } opcode_e;

  typedef struct packed {
    opcode_e op;
    logic    indirect;   // IR bit 8
    logic    is_halt;
    logic    mem_ref;    // AND through JMP
    addr_t   direct_ea;  // Zero page or current page
  } decoded_t;

  typedef struct packed {
    word_t ac;
    logic  link;
    addr_t pc;
  } regs_t;

  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  read_enable;
    logic  write_enable;
  } mem_req_t;

endpackage

// ==== logic/ctrl_pkg.sv ====
/* Sequencer states, per-register control codes and the control word
   passed from sequencer to datapath */
package ctrl_pkg;

  typedef enum logic [4:0] {
    REG_INIT, CPU_IDLE,
    LD_PC_1, LD_AC_1,
    FETCH_1, FETCH_2, FETCH_3, DECODE,
    CAL_EA_1, EA_IND_1, EA_IND_2,
    AND_1, AND_2, AND_3,
    TAD_1, TAD_2, TAD_3,
    ISZ_1, ISZ_2, ISZ_3, ISZ_4, ISZ_5, ISZ_6,
    DCA_1, DCA_2, DCA_3,
    JMS_1, JMS_2,
    JMP_1,
    HALT
  } seq_state_e;

  typedef enum logic [2:0] {AC_NC, AC_CLEAR, AC_AND, AC_TAD, AC_SWREG} ac_ctrl_e;

  typedef enum logic [1:0] {LK_NC, LK_ZERO, LK_TAD} lk_ctrl_e;

  typedef enum logic [2:0] {
    PC_NC, PC_ZERO, PC_P1, PC_SR, PC_EA, PC_EAP1, PC_SKIP_MB_ZERO
  } pc_ctrl_e;

  typedef enum logic {IR_NC, IR_LD} ir_ctrl_e;

  typedef enum logic [1:0] {EA_NC, EA_DIRECT, EA_IND} ea_ctrl_e;

  typedef enum logic [1:0] {MB_NC, MB_RD, MB_INC} mb_ctrl_e;

  typedef enum logic [1:0] {WD_NC, WD_AC, WD_PC, WD_MB} wd_ctrl_e;

  typedef enum logic [1:0] {AD_NC, AD_PC, AD_EA} ad_ctrl_e;

  typedef struct packed {
    ac_ctrl_e ac_ctrl;
    lk_ctrl_e lk_ctrl;
    pc_ctrl_e pc_ctrl;
    ir_ctrl_e ir_ctrl;
    ea_ctrl_e ea_ctrl;
    mb_ctrl_e mb_ctrl;
    wd_ctrl_e wd_ctrl;
    ad_ctrl_e ad_ctrl;
    logic     read_enable;
    logic     write_enable;
  } ctrl_t;

  localparam ctrl_t CTRL_NOP = '{
    ac_ctrl: AC_NC, lk_ctrl: LK_NC, pc_ctrl: PC_NC, ir_ctrl: IR_NC,
    ea_ctrl: EA_NC, mb_ctrl: MB_NC, wd_ctrl: WD_NC, ad_ctrl: AD_NC,
    read_enable: 1'b0, write_enable: 1'b0
  };

endpackage

// ==== logic/instr_decode.sv ====
/* Instruction decoder: opcode split, halt and memory-reference flags,
   direct effective address */
`timescale 1ns/1ps

module instr_decode
  import isa_pkg::*;
(
  input  word_t    ir,
  input  addr_t    pc,
  output decoded_t dec
);

  logic       cur_page;
  logic [6:0] offset;
  logic [4:0] page;
  opcode_e    op;

  assign op       = opcode_e'(ir[11:9]);
  assign cur_page = ir[7];
  assign offset   = ir[6:0];

  // PC has already been incremented past the instruction
  assign page = cur_page ? pc[11:7] : 5'b0;

  always_comb begin
    dec.op        = op;
    dec.indirect  = ir[8];
    dec.is_halt   = (ir == HALT_WORD);
    dec.mem_ref   = (op != OP_IOT) && (op != OP_OPR);
    dec.direct_ea = {page, offset};
  end

endmodule

// ==== logic/seq_control.sv ====
/* Moore sequencer for front-panel actions, fetch, effective address
   and memory-reference execution */
`timescale 1ns/1ps

module seq_control
  import isa_pkg::*;
  import ctrl_pkg::*;
(
  input  logic     clock,
  input  logic     resetN,
  input  logic     run,
  input  logic     step,
  input  logic     loadpc,
  input  logic     loadac,
  input  logic     mem_finished,
  input  decoded_t dec,
  output ctrl_t    ctrl,
  output logic     cpu_idle,
  output logic     halt
);

  seq_state_e state_q, state_d;
  seq_state_e exec_state;
  logic       mem_busy;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) state_q <= REG_INIT;
    else         state_q <= state_d;
  end

  // First execute state of a memory-reference instruction
  always_comb begin
    case (dec.op)
      OP_AND:  exec_state = AND_1;
      OP_TAD:  exec_state = TAD_1;
      OP_ISZ:  exec_state = ISZ_1;
      OP_DCA:  exec_state = DCA_1;
      OP_JMS:  exec_state = JMS_1;
      default: exec_state = JMP_1;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      REG_INIT: state_d = CPU_IDLE;
      CPU_IDLE: begin
        if (run || step) state_d = FETCH_1;
        else if (loadpc) state_d = LD_PC_1;
        else if (loadac) state_d = LD_AC_1;
      end
      LD_PC_1:  state_d = CPU_IDLE;
      LD_AC_1:  state_d = CPU_IDLE;
      FETCH_1:  state_d = FETCH_2;
      FETCH_2:  if (mem_finished) state_d = FETCH_3;
      FETCH_3:  state_d = DECODE;
      DECODE: begin
        if (dec.is_halt)      state_d = HALT;
        else if (dec.mem_ref) state_d = CAL_EA_1;
        else                  state_d = CPU_IDLE;  // IOT and OPR as no-ops
      end
      CAL_EA_1: state_d = dec.indirect ? EA_IND_1 : exec_state;
      EA_IND_1: state_d = EA_IND_2;
      EA_IND_2: if (mem_finished) state_d = exec_state;
      AND_1:    state_d = AND_2;
      AND_2:    if (mem_finished) state_d = AND_3;
      AND_3:    state_d = CPU_IDLE;
      TAD_1:    state_d = TAD_2;
      TAD_2:    if (mem_finished) state_d = TAD_3;
      TAD_3:    state_d = CPU_IDLE;
      ISZ_1:    state_d = ISZ_2;
      ISZ_2:    if (mem_finished) state_d = ISZ_3;
      ISZ_3:    state_d = ISZ_4;
      ISZ_4:    state_d = ISZ_5;
      ISZ_5:    if (mem_finished) state_d = ISZ_6;
      ISZ_6:    state_d = CPU_IDLE;
      DCA_1:    state_d = DCA_2;
      DCA_2:    if (mem_finished) state_d = DCA_3;
      DCA_3:    state_d = CPU_IDLE;
      JMS_1:    state_d = JMS_2;
      JMS_2:    if (mem_finished) state_d = CPU_IDLE;
      JMP_1:    state_d = CPU_IDLE;
      HALT:     state_d = CPU_IDLE;
      default:  state_d = CPU_IDLE;
    endcase
  end

  // Control codes depend on state only
  always_comb begin
    ctrl     = CTRL_NOP;
    cpu_idle = 1'b0;
    halt     = 1'b0;
    case (state_q)
      REG_INIT: begin
        ctrl.ac_ctrl = AC_CLEAR;
        ctrl.lk_ctrl = LK_ZERO;
        ctrl.pc_ctrl = PC_ZERO;       // Loads the reset PC
      end
      CPU_IDLE: cpu_idle = 1'b1;
      LD_PC_1:  ctrl.pc_ctrl = PC_SR;
      LD_AC_1:  ctrl.ac_ctrl = AC_SWREG;
      FETCH_1:  ctrl.ad_ctrl = AD_PC;
      FETCH_2: begin
        ctrl.read_enable = 1'b1;
        ctrl.mb_ctrl     = MB_RD;
      end
      FETCH_3: begin
        ctrl.ir_ctrl = IR_LD;
        ctrl.pc_ctrl = PC_P1;
      end
      CAL_EA_1: ctrl.ea_ctrl = EA_DIRECT;
      EA_IND_1: ctrl.ad_ctrl = AD_EA;
      EA_IND_2: begin
        ctrl.read_enable = 1'b1;
        ctrl.ea_ctrl     = EA_IND;       // Pointer word becomes the EA
      end
      AND_1, TAD_1, ISZ_1: ctrl.ad_ctrl = AD_EA;
      AND_2, TAD_2, ISZ_2: begin
        ctrl.read_enable = 1'b1;
        ctrl.mb_ctrl     = MB_RD;
      end
      AND_3:    ctrl.ac_ctrl = AC_AND;
      TAD_3: begin
        ctrl.ac_ctrl = AC_TAD;
        ctrl.lk_ctrl = LK_TAD;
      end
      ISZ_3:    ctrl.mb_ctrl = MB_INC;
      ISZ_4:    ctrl.wd_ctrl = WD_MB;
      ISZ_5:    ctrl.write_enable = 1'b1;
      ISZ_6:    ctrl.pc_ctrl = PC_SKIP_MB_ZERO;
      DCA_1: begin
        ctrl.ad_ctrl = AD_EA;
        ctrl.wd_ctrl = WD_AC;
      end
      DCA_2:    ctrl.write_enable = 1'b1;
      DCA_3:    ctrl.ac_ctrl = AC_CLEAR;
      JMS_1: begin
        ctrl.ad_ctrl = AD_EA;
        ctrl.wd_ctrl = WD_PC;         // Return address
      end
      JMS_2: begin
        ctrl.write_enable = 1'b1;
        ctrl.pc_ctrl      = PC_EAP1;
      end
      JMP_1:    ctrl.pc_ctrl = PC_EA;
      HALT: begin
        halt     = 1'b1;
        cpu_idle = 1'b1;
      end
      default: ;
    endcase
  end

  assign mem_busy = ctrl.read_enable | ctrl.write_enable;

  a_rd_wr_excl: assert property (@(posedge clock) disable iff (!resetN)
    !(ctrl.read_enable && ctrl.write_enable))
    else $error("read and write enable high together");

  // Wait states hold until memory answers
  a_wait_hold: assert property (@(posedge clock) disable iff (!resetN)
    mem_busy && !mem_finished |=> state_q == $past(state_q))
    else $error("memory wait state left without mem_finished");

endmodule

// ==== logic/reg_datapath.sv ====
/* Register datapath: AC, link, PC, IR, MB, EA, write data and address
   registers driven by the sequencer control codes */
`timescale 1ns/1ps

module reg_datapath
  import isa_pkg::*;
  import ctrl_pkg::*;
#(
  parameter addr_t RESET_PC = 12'o0200
) (
  input  logic     clock,
  input  logic     resetN,
  input  ctrl_t    ctrl,
  input  decoded_t dec,
  input  word_t    switch_reg,
  input  word_t    read_data,
  output word_t    ir,
  output mem_req_t mem_req,
  output regs_t    regs
);

  word_t       ac_q;
  logic        link_q;
  addr_t       pc_q;
  word_t       ir_q;
  word_t       mb_q;
  addr_t       ea_q;
  word_t       wd_q;
  addr_t       ad_q;
  logic [12:0] tad_sum;
  logic        mem_busy;

  assign tad_sum = {1'b0, ac_q} + {1'b0, mb_q};

  // Architectural state
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      ac_q   <= '0;
      link_q <= 1'b0;
      pc_q   <= RESET_PC;
    end else begin
      case (ctrl.ac_ctrl)
        AC_CLEAR: ac_q <= '0;
        AC_AND:   ac_q <= ac_q & mb_q;
        AC_TAD:   ac_q <= tad_sum[11:0];
        AC_SWREG: ac_q <= switch_reg;
        default:  ;
      endcase

      case (ctrl.lk_ctrl)
        LK_ZERO: link_q <= 1'b0;
        LK_TAD:  link_q <= link_q ^ tad_sum[12];  // Carry complements link
        default: ;
      endcase

      case (ctrl.pc_ctrl)
        PC_ZERO:         pc_q <= RESET_PC;
        PC_P1:           pc_q <= pc_q + 12'd1;
        PC_SR:           pc_q <= switch_reg;
        PC_EA:           pc_q <= ea_q;
        PC_EAP1:         pc_q <= ea_q + 12'd1;
        PC_SKIP_MB_ZERO: if (mb_q == '0) pc_q <= pc_q + 12'd1;
        default:         ;
      endcase
    end
  end

  // Working registers
  always_ff @(posedge clock) begin
    if (ctrl.ir_ctrl == IR_LD) ir_q <= mb_q;

    case (ctrl.ea_ctrl)
      EA_DIRECT: ea_q <= dec.direct_ea;
      EA_IND:    ea_q <= read_data;
      default:   ;
    endcase

    case (ctrl.mb_ctrl)
      MB_RD:   mb_q <= read_data;  // Last load lands on mem_finished
      MB_INC:  mb_q <= mb_q + 12'd1;
      default: ;
    endcase

    case (ctrl.wd_ctrl)
      WD_AC:   wd_q <= ac_q;
      WD_PC:   wd_q <= pc_q;
      WD_MB:   wd_q <= mb_q;
      default: ;
    endcase

    case (ctrl.ad_ctrl)
      AD_PC:   ad_q <= pc_q;
      AD_EA:   ad_q <= ea_q;
      default: ;
    endcase
  end

  assign ir = ir_q;

  assign regs = '{ac: ac_q, link: link_q, pc: pc_q};

  assign mem_req = '{
    addr:         ad_q,
    wdata:        wd_q,
    read_enable:  ctrl.read_enable,
    write_enable: ctrl.write_enable
  };

  assign mem_busy = ctrl.read_enable | ctrl.write_enable;

  a_req_stable: assert property (@(posedge clock) disable iff (!resetN)
    mem_busy |=> !mem_busy || ($stable(ad_q) && $stable(wd_q)))
    else $error("memory address or write data changed during a request");

endmodule

// ==== logic/pdp8_core.sv ====
/* Core top level: decoder, sequencer and register datapath */
`timescale 1ns/1ps

module pdp8_core
  import isa_pkg::*;
  import ctrl_pkg::*;
#(
  parameter addr_t RESET_PC = 12'o0200
) (
  input  logic     clock,
  input  logic     resetN,
  input  logic     run,
  input  logic     step,
  input  logic     loadpc,
  input  logic     loadac,
  input  word_t    switch_reg,
  input  word_t    read_data,
  input  logic     mem_finished,
  output mem_req_t mem_req,
  output regs_t    regs,
  output logic     cpu_idle,
  output logic     halt
);

  word_t    ir;
  decoded_t dec;
  ctrl_t    ctrl;

  instr_decode u_decode (
    .ir  (ir),
    .pc  (regs.pc),
    .dec (dec)
  );

  seq_control u_seq (
    .clock        (clock),
    .resetN       (resetN),
    .run          (run),
    .step         (step),
    .loadpc       (loadpc),
    .loadac       (loadac),
    .mem_finished (mem_finished),
    .dec          (dec),
    .ctrl         (ctrl),
    .cpu_idle     (cpu_idle),
    .halt         (halt)
  );

  reg_datapath #(
    .RESET_PC (RESET_PC)
  ) u_datapath (
    .clock      (clock),
    .resetN     (resetN),
    .ctrl       (ctrl),
    .dec        (dec),
    .switch_reg (switch_reg),
    .read_data  (read_data),
    .ir         (ir),
    .mem_req    (mem_req),
    .regs       (regs)
  );

endmodule

// ==== dv/tb_clock.sv ====
/* Testbench clock and reset generator */
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clock,
  output logic resetN
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  initial begin
    resetN = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #2 resetN = 1'b1;  // Released just after an edge
  end

endmodule

// ==== dv/pdp8_tb.sv ====
/* PDP-8 core testbench: memory model with random latency, stimulus table,
   reference model and result checks */
`timescale 1ns/1ps

module pdp8_tb
  import isa_pkg::*;
();

  localparam int DRIVE_DELAY = 2;
  localparam int IDLE_LIMIT  = 200;
  localparam int NUM_STIM    = 21;

  typedef enum {PULSE_RUN, PULSE_STEP, PULSE_LOADPC, PULSE_LOADAC} pulse_e;

  typedef struct packed {
    word_t start_ac;
    addr_t start_pc;
    word_t instr;
    word_t operand;
    addr_t oper_addr;  // Pointer contents when indirect
    logic  rand_op;
    logic  use_step;
  } stim_t;

  typedef struct packed {
    regs_t regs;
    word_t mem_word;
    logic  halt;
  } result_t;

  logic        clock, resetN;
  logic        run, step, loadpc, loadac;
  word_t       switch_reg, read_data;
  logic        mem_finished;
  mem_req_t    mem_req;
  regs_t       regs;
  logic        cpu_idle, halt;
  word_t       mem [0:4095];
  stim_t       stim_table [NUM_STIM];
  logic [31:0] lfsr_state;
  logic        mem_busy;
  int          mem_wait;
  int          value_errors, other_errors;
  logic        exp_link;
  logic        timed_out;

  tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(16)) u_clock (.clock(clock), .resetN(resetN));

  pdp8_core #(.RESET_PC(12'o0200)) dut (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  function automatic word_t take_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[10:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // Memory answers each request after 1 to 4 cycles
  always @(posedge clock) begin
    #DRIVE_DELAY;
    if (mem_finished) begin
      mem_finished = 1'b0;
      read_data    = 12'o1717;
    end else if (mem_req.read_enable || mem_req.write_enable) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        mem_wait = int'(take_bits(2));
      end else begin
        mem_wait = mem_wait - 1;
      end
      if (mem_wait == 0) begin
        if (mem_req.write_enable) mem[mem_req.addr] = mem_req.wdata;
        else read_data = mem[mem_req.addr];
        mem_finished = 1'b1;
        mem_busy     = 1'b0;
      end
    end
  end

  function automatic addr_t direct_ea(input word_t instr, input addr_t pc_next);
    if (instr[7]) return {pc_next[11:7], instr[6:0]};  // Current page
    return {5'b0, instr[6:0]};
  endfunction

  function automatic result_t predict_result(input stim_t s, input logic link_in);
    result_t     r;
    addr_t       pc_next;
    addr_t       ea;
    logic [12:0] sum;
    pc_next    = s.start_pc + 12'd1;
    ea         = s.instr[8] ? s.oper_addr : direct_ea(s.instr, pc_next);
    r.regs     = '{ac: s.start_ac, link: link_in, pc: pc_next};
    r.mem_word = s.operand;
    r.halt     = (s.instr == 12'o7402);
    case (s.instr[11:9])
      3'o0: r.regs.ac = s.start_ac & s.operand;
      3'o1: begin
        sum         = {1'b0, s.start_ac} + {1'b0, s.operand};
        r.regs.ac   = sum[11:0];
        r.regs.link = link_in ^ sum[12];  // Carry complements the link
      end
      3'o2: begin
        r.mem_word = s.operand + 12'd1;
        if (r.mem_word == '0) r.regs.pc = pc_next + 12'd1;
      end
      3'o3: begin
        r.mem_word = s.start_ac;
        r.regs.ac  = '0;
      end
      3'o4: begin
        r.mem_word = pc_next;  // Return address
        r.regs.pc  = ea + 12'd1;
      end
      3'o5: r.regs.pc = ea;
      default: ;
    endcase
    return r;
  endfunction

  task automatic check_regs(input string name, input regs_t got, input regs_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s: expected ac=%o link=%b pc=%o, got ac=%o link=%b pc=%o",
               $time, name, exp.ac, exp.link, exp.pc, got.ac, got.link, got.pc);
      value_errors++;
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s: expected %o, got %o", $time, name, exp, got);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s: expected %b, got %b", $time, name, exp, got);
      value_errors++;
    end
  endtask

  task automatic end_run;
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  task automatic drive_pulse(input pulse_e kind, input logic level);
    case (kind)
      PULSE_RUN:    run = level;
      PULSE_STEP:   step = level;
      PULSE_LOADPC: loadpc = level;
      default:      loadac = level;
    endcase
  endtask

  // Called just after an edge with the core idle
  task automatic pulse_and_wait(input pulse_e kind);
    int cycles;
    drive_pulse(kind, 1'b1);
    @(posedge clock);
    #DRIVE_DELAY;
    drive_pulse(kind, 1'b0);
    cycles = 1;
    while (cpu_idle !== 1'b1 && cycles < IDLE_LIMIT) begin
      @(posedge clock);
      #DRIVE_DELAY;
      cycles++;
    end
    if (cpu_idle !== 1'b1) begin
      $display("timeout: core did not return to idle after a front-panel pulse at %0t", $time);
      other_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic build_table;
    // Columns: AC, PC, instruction, operand, operand address, random operand, step
    stim_table[0]  = '{12'o7070, 12'o0200, 12'o0040, 12'o0000, 12'o0040, 1'b1, 1'b0};
    stim_table[1]  = '{12'o1234, 12'o0210, 12'o1041, 12'o0000, 12'o0041, 1'b1, 1'b0};
    stim_table[2]  = '{12'o4000, 12'o0400, 12'o1350, 12'o4000, 12'o0550, 1'b0, 1'b0};
    stim_table[3]  = '{12'o7777, 12'o1000, 12'o0225, 12'o0000, 12'o1025, 1'b1, 1'b1};
    stim_table[4]  = '{12'o7777, 12'o0220, 12'o1042, 12'o0001, 12'o0042, 1'b0, 1'b1};
    // Indirect through a pointer word
    stim_table[5]  = '{12'o6363, 12'o0230, 12'o0443, 12'o0000, 12'o2000, 1'b1, 1'b0};
    stim_table[6]  = '{12'o0707, 12'o0600, 12'o1677, 12'o0000, 12'o3000, 1'b1, 1'b0};
    stim_table[7]  = '{12'o5252, 12'o0240, 12'o3444, 12'o0000, 12'o2100, 1'b1, 1'b0};
    stim_table[8]  = '{12'o1357, 12'o0250, 12'o3045, 12'o0000, 12'o0045, 1'b1, 1'b1};
    stim_table[9]  = '{12'o0000, 12'o0260, 12'o2046, 12'o7777, 12'o0046, 1'b0, 1'b0};
    stim_table[10] = '{12'o0000, 12'o0270, 12'o2047, 12'o0123, 12'o0047, 1'b0, 1'b0};
    stim_table[11] = '{12'o0000, 12'o1200, 12'o2610, 12'o7777, 12'o3100, 1'b0, 1'b1};
    stim_table[12] = '{12'o0000, 12'o0300, 12'o4050, 12'o0000, 12'o0050, 1'b1, 1'b0};
    stim_table[13] = '{12'o0000, 12'o1400, 12'o4260, 12'o0000, 12'o1460, 1'b1, 1'b0};
    stim_table[14] = '{12'o0000, 12'o0310, 12'o5051, 12'o0000, 12'o0051, 1'b1, 1'b0};
    stim_table[15] = '{12'o0000, 12'o0320, 12'o5452, 12'o0000, 12'o2200, 1'b1, 1'b1};
    stim_table[16] = '{12'o0000, 12'o1600, 12'o5323, 12'o0000, 12'o1723, 1'b1, 1'b0};
    // Halt word and no-ops
    stim_table[17] = '{12'o3333, 12'o0330, 12'o7402, 12'o0000, 12'o0000, 1'b0, 1'b0};
    stim_table[18] = '{12'o2525, 12'o0340, 12'o6031, 12'o0000, 12'o0000, 1'b0, 1'b0};
    stim_table[19] = '{12'o1111, 12'o0350, 12'o7001, 12'o0000, 12'o0000, 1'b0, 1'b1};
    stim_table[20] = '{12'o4444, 12'o0360, 12'o7402, 12'o0000, 12'o0000, 1'b0, 1'b1};
    for (int i = 0; i < NUM_STIM; i++) begin
      if (stim_table[i].rand_op) stim_table[i].operand = take_bits(12);
    end
  endtask

  task automatic apply_entry(input int idx);
    stim_t   s;
    result_t exp;
    addr_t   ea_dir;
    logic    mem_ref;
    s       = stim_table[idx];
    ea_dir  = direct_ea(s.instr, s.start_pc + 12'd1);
    mem_ref = s.instr[11:9] < 3'o6;
    switch_reg = s.start_pc;
    pulse_and_wait(PULSE_LOADPC);
    if (timed_out) return;
    check_word("regs.pc after loadpc", regs.pc, s.start_pc);
    switch_reg = s.start_ac;
    pulse_and_wait(PULSE_LOADAC);
    if (timed_out) return;
    check_word("regs.ac after loadac", regs.ac, s.start_ac);
    mem[s.start_pc] = s.instr;
    if (mem_ref && s.instr[8]) begin
      mem[ea_dir] = s.oper_addr;  // Pointer word
    end else if (mem_ref && s.oper_addr != ea_dir) begin
      $display("stimulus entry %0d: operand address %o is not the direct address %o",
               idx, s.oper_addr, ea_dir);
      other_errors++;
    end
    if (mem_ref) mem[s.oper_addr] = s.operand;
    exp = predict_result(s, exp_link);
    pulse_and_wait(s.use_step ? PULSE_STEP : PULSE_RUN);
    if (timed_out) return;
    check_flag("halt", halt, exp.halt);
    check_regs("regs", regs, exp.regs);
    if (mem_ref) check_word("mem[ea]", mem[s.oper_addr], exp.mem_word);
    @(posedge clock);
    #DRIVE_DELAY;
    check_flag("halt", halt, 1'b0);  // High for one cycle only
    check_flag("cpu_idle", cpu_idle, 1'b1);
    exp_link = exp.regs.link;
  endtask

  initial begin : main
    int n;
    run          = 1'b0;
    step         = 1'b0;
    loadpc       = 1'b0;
    loadac       = 1'b0;
    switch_reg   = '0;
    read_data    = '0;
    mem_finished = 1'b0;
    mem_busy     = 1'b0;
    mem_wait     = 0;
    value_errors = 0;
    other_errors = 0;
    exp_link     = 1'b0;
    timed_out    = 1'b0;
    lfsr_state   = 32'h5a0e;
    for (int a = 0; a < 4096; a++) mem[a] = word_t'(a) ^ 12'o3525;
    build_table();
    n = 0;
    do begin
      @(posedge clock);
      #DRIVE_DELAY;
      n++;
    end while (cpu_idle !== 1'b1 && n < 40);
    if (cpu_idle !== 1'b1) begin
      $display("timeout: core never reached idle after reset");
      other_errors++;
    end else begin
      check_regs("regs after reset", regs, {12'o0000, 1'b0, 12'o0200});
      check_flag("halt after reset", halt, 1'b0);
      for (int i = 0; i < NUM_STIM && !timed_out; i++) apply_entry(i);
    end
    end_run();
  end

endmodule

// ==== sources.f ====
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/instr_decode.sv
logic/seq_control.sv
logic/reg_datapath.sv
logic/pdp8_core.sv
dv/tb_clock.sv
dv/pdp8_tb.sv

// ==== Bender.yml ====
package:
  name: pdp8_core

sources:
  - files:
      - logic/isa_pkg.sv
      - logic/ctrl_pkg.sv
      - logic/instr_decode.sv
      - logic/seq_control.sv
      - logic/reg_datapath.sv
      - logic/pdp8_core.sv
  - target: simulation
    files:
      - dv/tb_clock.sv
      - dv/pdp8_tb.sv
